/* hw/gemm_pkg.sv */
// ##################
// Shared widths, register map and encodings for the GEMM accelerator
// Imported by the RTL blocks that need them
// ##################

package gemm_pkg;

  // Bus and element widths
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned ELEM_W = 8;
  localparam int unsigned K_W    = 8;

  // Default array shape, one packed word per row and per column
  localparam int unsigned ARRAY_WIDTH  = 4;
  localparam int unsigned ARRAY_HEIGHT = 4;

  // Peripheral register offsets
  localparam logic [7:0] REG_X_ADDR  = 8'h40;
  localparam logic [7:0] REG_W_ADDR  = 8'h44;
  localparam logic [7:0] REG_Y_ADDR  = 8'h48;
  localparam logic [7:0] REG_Z_ADDR  = 8'h4C;
  localparam logic [7:0] REG_K       = 8'h50;
  localparam logic [7:0] REG_TRIGGER = 8'h54;
  localparam logic [7:0] REG_STATUS  = 8'h58;

  typedef enum logic [2:0] {
    IDLE,
    LOAD_Y,
    LOAD_X,
    LOAD_W,
    MAC,
    STORE,
    DONE
  } sched_state_e;

  // Where a returned read word is steered
  typedef enum logic [1:0] {
    TGT_Y,
    TGT_X,
    TGT_W
  } load_target_e;

endpackage

/* hw/gemm_regfile.sv */
// ##################
// Configuration registers and job control
// A write to the trigger offset while idle starts a job
// ##################
`timescale 1ns/1ps

module gemm_regfile (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        periph_req_i,
  input  logic                        periph_we_i,
  input  logic [7:0]                  periph_addr_i,
  input  logic [gemm_pkg::DATA_W-1:0] periph_wdata_i,
  input  logic                        done_i,
  output logic                        periph_gnt_o,
  output logic [gemm_pkg::DATA_W-1:0] periph_rdata_o,
  output logic [gemm_pkg::ADDR_W-1:0] x_addr_o,
  output logic [gemm_pkg::ADDR_W-1:0] w_addr_o,
  output logic [gemm_pkg::ADDR_W-1:0] y_addr_o,
  output logic [gemm_pkg::ADDR_W-1:0] z_addr_o,
  output logic [gemm_pkg::K_W-1:0]    k_o,
  output logic                        start_o,
  output logic                        busy_o,
  output logic                        evt_o
);
  import gemm_pkg::*;

  logic cfg_we;
  logic trigger;

  // Always ready, so the grant follows the request
  assign periph_gnt_o = periph_req_i;

  // Configuration is frozen while a job runs
  assign cfg_we  = periph_req_i && periph_we_i && !busy_o;
  assign trigger = cfg_we && (periph_addr_i == REG_TRIGGER);

  always_ff @(posedge clk_i) begin
    if (cfg_we) begin
      case (periph_addr_i)
        REG_X_ADDR: x_addr_o <= periph_wdata_i[ADDR_W-1:0];
        REG_W_ADDR: w_addr_o <= periph_wdata_i[ADDR_W-1:0];
        REG_Y_ADDR: y_addr_o <= periph_wdata_i[ADDR_W-1:0];
        REG_Z_ADDR: z_addr_o <= periph_wdata_i[ADDR_W-1:0];
        REG_K:      k_o      <= periph_wdata_i[K_W-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      start_o <= 1'b0;
      busy_o  <= 1'b0;
      evt_o   <= 1'b0;
    end else begin
      start_o <= trigger;
      evt_o   <= done_i;
      // busy drops on the same edge that raises the event
      if (trigger) begin
        busy_o <= 1'b1;
      end else if (done_i) begin
        busy_o <= 1'b0;
      end
    end
  end

  always_comb begin
    periph_rdata_o = '0;
    case (periph_addr_i)
      REG_X_ADDR: periph_rdata_o = DATA_W'(x_addr_o);
      REG_W_ADDR: periph_rdata_o = DATA_W'(w_addr_o);
      REG_Y_ADDR: periph_rdata_o = DATA_W'(y_addr_o);
      REG_Z_ADDR: periph_rdata_o = DATA_W'(z_addr_o);
      REG_K:      periph_rdata_o = DATA_W'(k_o);
      REG_STATUS: periph_rdata_o = DATA_W'(busy_o);
      default: ;
    endcase
  end

endmodule

/* hw/gemm_scheduler.sv */
// ##################
// Job sequencer FSM
// Y preload, then K rounds of X load, W load and MAC, then Z store
// ##################
`timescale 1ns/1ps

module gemm_scheduler #(
  parameter int unsigned Width = gemm_pkg::ARRAY_WIDTH
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        start_i,
  input  logic [gemm_pkg::ADDR_W-1:0] x_addr_i,
  input  logic [gemm_pkg::ADDR_W-1:0] w_addr_i,
  input  logic [gemm_pkg::ADDR_W-1:0] y_addr_i,
  input  logic [gemm_pkg::ADDR_W-1:0] z_addr_i,
  input  logic [gemm_pkg::K_W-1:0]    k_i,
  input  logic                        rd_done_i,
  input  logic                        wr_done_i,
  output logic                        rd_start_o,
  output logic [gemm_pkg::ADDR_W-1:0] rd_base_o,
  output logic [gemm_pkg::K_W-1:0]    rd_count_o,
  output gemm_pkg::load_target_e      rd_target_o,
  output logic                        wr_start_o,
  output logic [gemm_pkg::ADDR_W-1:0] wr_base_o,
  output logic                        mac_en_o,
  output logic                        done_o
);
  import gemm_pkg::*;

  sched_state_e state_q, state_d;
  logic [K_W-1:0] k_cnt_q;
  logic last_step;

  assign last_step = (k_cnt_q == k_i - 1'b1);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start_i) state_d = LOAD_Y;
      // A zero depth leaves Z equal to Y
      LOAD_Y:  if (rd_done_i) state_d = (k_i == '0) ? STORE : LOAD_X;
      LOAD_X:  if (rd_done_i) state_d = LOAD_W;
      LOAD_W:  if (rd_done_i) state_d = MAC;
      MAC:     state_d = last_step ? STORE : LOAD_X;
      STORE:   if (wr_done_i) state_d = DONE;
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= IDLE;
      k_cnt_q    <= '0;
      rd_start_o <= 1'b0;
      wr_start_o <= 1'b0;
    end else begin
      state_q    <= state_d;
      // Start pulses land in the first cycle of the new state
      rd_start_o <= (state_d != state_q) &&
                    (state_d inside {LOAD_Y, LOAD_X, LOAD_W});
      wr_start_o <= (state_d != state_q) && (state_d == STORE);
      if (state_q == IDLE) begin
        k_cnt_q <= '0;
      end else if (state_q == MAC) begin
        k_cnt_q <= k_cnt_q + 1'b1;
      end
    end
  end

  // Read setup, sampled by the load unit on rd_start
  always_comb begin
    rd_base_o   = y_addr_i;
    rd_count_o  = K_W'(Width);
    rd_target_o = TGT_Y;
    if (state_q == LOAD_X) begin
      rd_base_o   = x_addr_i + ADDR_W'(k_cnt_q);
      rd_count_o  = K_W'(1);
      rd_target_o = TGT_X;
    end else if (state_q == LOAD_W) begin
      rd_base_o   = w_addr_i + ADDR_W'(k_cnt_q);
      rd_count_o  = K_W'(1);
      rd_target_o = TGT_W;
    end
  end

  assign wr_base_o = z_addr_i;
  assign mac_en_o  = (state_q == MAC);
  assign done_o    = (state_q == DONE);

endmodule

/* hw/gemm_mem_arbiter.sv */
// ##################
// Shares the memory port between the store and load units
// Store has fixed priority, read data goes back to the load unit
// ##################
`timescale 1ns/1ps

module gemm_mem_arbiter (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        ld_req_i,
  input  logic [gemm_pkg::ADDR_W-1:0] ld_addr_i,
  input  logic                        st_req_i,
  input  logic [gemm_pkg::ADDR_W-1:0] st_addr_i,
  input  logic [gemm_pkg::DATA_W-1:0] st_wdata_i,
  input  logic                        mem_gnt_i,
  input  logic                        mem_rvalid_i,
  input  logic [gemm_pkg::DATA_W-1:0] mem_rdata_i,
  output logic                        ld_gnt_o,
  output logic                        st_gnt_o,
  output logic                        ld_rvalid_o,
  output logic [gemm_pkg::DATA_W-1:0] ld_rdata_o,
  output logic                        mem_req_o,
  output logic                        mem_we_o,
  output logic [gemm_pkg::ADDR_W-1:0] mem_addr_o,
  output logic [gemm_pkg::DATA_W-1:0] mem_wdata_o
);

  logic ld_owns_rd_q;

  assign mem_req_o   = st_req_i || ld_req_i;
  assign mem_we_o    = st_req_i;
  assign mem_addr_o  = st_req_i ? st_addr_i : ld_addr_i;
  assign mem_wdata_o = st_wdata_i;

  assign st_gnt_o = st_req_i && mem_gnt_i;
  assign ld_gnt_o = !st_req_i && ld_req_i && mem_gnt_i;

  // Read data returns one cycle after the grant
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ld_owns_rd_q <= 1'b0;
    end else begin
      ld_owns_rd_q <= ld_gnt_o;
    end
  end

  assign ld_rvalid_o = mem_rvalid_i && ld_owns_rd_q;
  assign ld_rdata_o  = mem_rdata_i;

endmodule

/* hw/gemm_load_unit.sv */
// ##################
// Reads a run of consecutive words from memory
// Each returned word is tagged with its target and row for the engine
// ##################
`timescale 1ns/1ps

module gemm_load_unit (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        rd_start_i,
  input  logic [gemm_pkg::ADDR_W-1:0] rd_base_i,
  input  logic [gemm_pkg::K_W-1:0]    rd_count_i,
  input  gemm_pkg::load_target_e      rd_target_i,
  input  logic                        req_gnt_i,
  input  logic                        rvalid_i,
  input  logic [gemm_pkg::DATA_W-1:0] rdata_i,
  output logic                        req_o,
  output logic [gemm_pkg::ADDR_W-1:0] req_addr_o,
  output logic                        rd_done_o,
  output logic                        word_valid_o,
  output logic [gemm_pkg::DATA_W-1:0] word_data_o,
  output gemm_pkg::load_target_e      word_target_o,
  output logic [gemm_pkg::K_W-1:0]    word_row_o
);
  import gemm_pkg::*;

  logic active_q;
  logic [ADDR_W-1:0] base_q;
  logic [K_W-1:0] count_q, issued_q, returned_q;
  load_target_e target_q;

  // Next request may go out in the grant cycle of the previous one
  assign req_o      = active_q && (issued_q != count_q);
  assign req_addr_o = base_q + ADDR_W'(issued_q);

  assign word_valid_o  = active_q && rvalid_i;
  assign word_data_o   = rdata_i;
  assign word_target_o = target_q;
  assign word_row_o    = returned_q;

  always_ff @(posedge clk_i) begin
    if (rd_start_i) begin
      base_q   <= rd_base_i;
      count_q  <= rd_count_i;
      target_q <= rd_target_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q   <= 1'b0;
      issued_q   <= '0;
      returned_q <= '0;
      rd_done_o  <= 1'b0;
    end else begin
      rd_done_o <= 1'b0;
      if (rd_start_i) begin
        active_q   <= 1'b1;
        issued_q   <= '0;
        returned_q <= '0;
      end else if (active_q) begin
        if (req_gnt_i) begin
          issued_q <= issued_q + 1'b1;
        end
        if (rvalid_i) begin
          returned_q <= returned_q + 1'b1;
          if (returned_q + 1'b1 == count_q) begin
            active_q  <= 1'b0;
            rd_done_o <= 1'b1;
          end
        end
      end
    end
  end

endmodule

/* hw/gemm_engine.sv */
// ##################
// Width x Height array of 8-bit multiply-accumulate cells
// X gives one element per row, W one element per column
// ##################
`timescale 1ns/1ps

module gemm_engine #(
  parameter int unsigned Width  = gemm_pkg::ARRAY_WIDTH,
  parameter int unsigned Height = gemm_pkg::ARRAY_HEIGHT
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 word_valid_i,
  input  logic [gemm_pkg::DATA_W-1:0]          word_data_i,
  input  gemm_pkg::load_target_e               word_target_i,
  input  logic [gemm_pkg::K_W-1:0]             word_row_i,
  input  logic                                 mac_en_i,
  output logic [Width-1:0][gemm_pkg::DATA_W-1:0] acc_rows_o
);
  import gemm_pkg::*;

  logic [Width-1:0][ELEM_W-1:0]              x_q;
  logic [Height-1:0][ELEM_W-1:0]             w_q;
  logic [Width-1:0][Height-1:0][ELEM_W-1:0]  acc_q;

  // Operand registers, element i sits at bits i*ELEM_W
  always_ff @(posedge clk_i) begin
    if (word_valid_i && word_target_i == TGT_X) begin
      x_q <= word_data_i;
    end
    if (word_valid_i && word_target_i == TGT_W) begin
      w_q <= word_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      acc_q <= '0;
    end else if (mac_en_i) begin
      // Low ELEM_W bits of the product are the same signed or unsigned,
      // so the sum wraps modulo 256
      for (int r = 0; r < Width; r++) begin
        for (int c = 0; c < Height; c++) begin
          acc_q[r][c] <= acc_q[r][c] + x_q[r] * w_q[c];
        end
      end
    end else if (word_valid_i && word_target_i == TGT_Y) begin
      for (int r = 0; r < Width; r++) begin
        if (word_row_i == K_W'(r)) begin
          acc_q[r] <= word_data_i;
        end
      end
    end
  end

  // One packed Z word per row
  assign acc_rows_o = acc_q;

endmodule

/* hw/gemm_store_unit.sv */
// ##################
// Writes the accumulator rows to consecutive words from the Z base
// One row per granted write
// ##################
`timescale 1ns/1ps

module gemm_store_unit #(
  parameter int unsigned Width = gemm_pkg::ARRAY_WIDTH
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 wr_start_i,
  input  logic [gemm_pkg::ADDR_W-1:0]          wr_base_i,
  input  logic [Width-1:0][gemm_pkg::DATA_W-1:0] acc_rows_i,
  input  logic                                 req_gnt_i,
  output logic                                 req_o,
  output logic [gemm_pkg::ADDR_W-1:0]          req_addr_o,
  output logic [gemm_pkg::DATA_W-1:0]          req_wdata_o,
  output logic                                 wr_done_o
);
  import gemm_pkg::*;

  logic active_q;
  logic [K_W-1:0] row_q;
  logic [ADDR_W-1:0] base_q;

  assign req_o       = active_q;
  assign req_addr_o  = base_q + ADDR_W'(row_q);
  assign req_wdata_o = acc_rows_i[row_q];

  always_ff @(posedge clk_i) begin
    if (wr_start_i) begin
      base_q <= wr_base_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      active_q  <= 1'b0;
      row_q     <= '0;
      wr_done_o <= 1'b0;
    end else begin
      wr_done_o <= 1'b0;
      if (wr_start_i) begin
        active_q <= 1'b1;
        row_q    <= '0;
      end else if (active_q && req_gnt_i) begin
        if (row_q == K_W'(Width - 1)) begin
          active_q  <= 1'b0;
          wr_done_o <= 1'b1;
        end else begin
          row_q <= row_q + 1'b1;
        end
      end
    end
  end

endmodule

/* hw/gemm_top.sv */
// ##################
// Top level of the integer GEMM accelerator, Z = X*W + Y
// Configured through the peripheral port, one master port to memory
// ##################
`timescale 1ns/1ps

module gemm_top #(
  parameter int unsigned Width  = gemm_pkg::ARRAY_WIDTH,
  parameter int unsigned Height = gemm_pkg::ARRAY_HEIGHT
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  // Peripheral configuration port
  input  logic                        periph_req_i,
  input  logic                        periph_we_i,
  input  logic [7:0]                  periph_addr_i,
  input  logic [gemm_pkg::DATA_W-1:0] periph_wdata_i,
  output logic                        periph_gnt_o,
  output logic [gemm_pkg::DATA_W-1:0] periph_rdata_o,
  // Memory master port
  output logic                        mem_req_o,
  output logic                        mem_we_o,
  output logic [gemm_pkg::ADDR_W-1:0] mem_addr_o,
  output logic [gemm_pkg::DATA_W-1:0] mem_wdata_o,
  input  logic                        mem_gnt_i,
  input  logic [gemm_pkg::DATA_W-1:0] mem_rdata_i,
  input  logic                        mem_rvalid_i,
  output logic                        busy_o,
  output logic                        evt_o
);
  import gemm_pkg::*;

  logic start, done, mac_en;
  logic [ADDR_W-1:0] x_addr, w_addr, y_addr, z_addr;
  logic [K_W-1:0] k;

  // Scheduler to load and store units
  logic rd_start, rd_done, wr_start, wr_done;
  logic [ADDR_W-1:0] rd_base, wr_base;
  logic [K_W-1:0] rd_count;
  load_target_e rd_target;

  // Unit side of the arbiter
  logic ld_req, ld_gnt, ld_rvalid;
  logic st_req, st_gnt;
  logic [ADDR_W-1:0] ld_addr, st_addr;
  logic [DATA_W-1:0] ld_rdata, st_wdata;

  // Returned words toward the engine
  logic word_valid;
  logic [DATA_W-1:0] word_data;
  load_target_e word_target;
  logic [K_W-1:0] word_row;
  logic [Width-1:0][DATA_W-1:0] acc_rows;

  gemm_regfile i_regfile (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .periph_req_i   ( periph_req_i   ),
    .periph_we_i    ( periph_we_i    ),
    .periph_addr_i  ( periph_addr_i  ),
    .periph_wdata_i ( periph_wdata_i ),
    .done_i         ( done           ),
    .periph_gnt_o   ( periph_gnt_o   ),
    .periph_rdata_o ( periph_rdata_o ),
    .x_addr_o       ( x_addr         ),
    .w_addr_o       ( w_addr         ),
    .y_addr_o       ( y_addr         ),
    .z_addr_o       ( z_addr         ),
    .k_o            ( k              ),
    .start_o        ( start          ),
    .busy_o         ( busy_o         ),
    .evt_o          ( evt_o          )
  );

  gemm_scheduler #(
    .Width ( Width )
  ) i_scheduler (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .start_i     ( start     ),
    .x_addr_i    ( x_addr    ),
    .w_addr_i    ( w_addr    ),
    .y_addr_i    ( y_addr    ),
    .z_addr_i    ( z_addr    ),
    .k_i         ( k         ),
    .rd_done_i   ( rd_done   ),
    .wr_done_i   ( wr_done   ),
    .rd_start_o  ( rd_start  ),
    .rd_base_o   ( rd_base   ),
    .rd_count_o  ( rd_count  ),
    .rd_target_o ( rd_target ),
    .wr_start_o  ( wr_start  ),
    .wr_base_o   ( wr_base   ),
    .mac_en_o    ( mac_en    ),
    .done_o      ( done      )
  );

  gemm_load_unit i_load_unit (
    .clk_i         ( clk_i       ),
    .reset_i       ( reset_i     ),
    .rd_start_i    ( rd_start    ),
    .rd_base_i     ( rd_base     ),
    .rd_count_i    ( rd_count    ),
    .rd_target_i   ( rd_target   ),
    .req_gnt_i     ( ld_gnt      ),
    .rvalid_i      ( ld_rvalid   ),
    .rdata_i       ( ld_rdata    ),
    .req_o         ( ld_req      ),
    .req_addr_o    ( ld_addr     ),
    .rd_done_o     ( rd_done     ),
    .word_valid_o  ( word_valid  ),
    .word_data_o   ( word_data   ),
    .word_target_o ( word_target ),
    .word_row_o    ( word_row    )
  );

  gemm_store_unit #(
    .Width ( Width )
  ) i_store_unit (
    .clk_i       ( clk_i    ),
    .reset_i     ( reset_i  ),
    .wr_start_i  ( wr_start ),
    .wr_base_i   ( wr_base  ),
    .acc_rows_i  ( acc_rows ),
    .req_gnt_i   ( st_gnt   ),
    .req_o       ( st_req   ),
    .req_addr_o  ( st_addr  ),
    .req_wdata_o ( st_wdata ),
    .wr_done_o   ( wr_done  )
  );

  gemm_mem_arbiter i_mem_arbiter (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .ld_req_i     ( ld_req       ),
    .ld_addr_i    ( ld_addr      ),
    .st_req_i     ( st_req       ),
    .st_addr_i    ( st_addr      ),
    .st_wdata_i   ( st_wdata     ),
    .mem_gnt_i    ( mem_gnt_i    ),
    .mem_rvalid_i ( mem_rvalid_i ),
    .mem_rdata_i  ( mem_rdata_i  ),
    .ld_gnt_o     ( ld_gnt       ),
    .st_gnt_o     ( st_gnt       ),
    .ld_rvalid_o  ( ld_rvalid    ),
    .ld_rdata_o   ( ld_rdata     ),
    .mem_req_o    ( mem_req_o    ),
    .mem_we_o     ( mem_we_o     ),
    .mem_addr_o   ( mem_addr_o   ),
    .mem_wdata_o  ( mem_wdata_o  )
  );

  gemm_engine #(
    .Width  ( Width  ),
    .Height ( Height )
  ) i_engine (
    .clk_i         ( clk_i       ),
    .reset_i       ( reset_i     ),
    .word_valid_i  ( word_valid  ),
    .word_data_i   ( word_data   ),
    .word_target_i ( word_target ),
    .word_row_i    ( word_row    ),
    .mac_en_i      ( mac_en      ),
    .acc_rows_o    ( acc_rows    )
  );

endmodule

/* dv/gemm_properties.sv */
// ##################
// Concurrent assertions on the memory bus and job control
// Bound to gemm_top, failures are counted in fail_cnt
// ##################
`timescale 1ns/1ps

module gemm_properties (
  input logic                        clk_i,
  input logic                        reset_i,
  input logic                        mem_req_i,
  input logic                        mem_we_i,
  input logic                        mem_gnt_i,
  input logic [gemm_pkg::ADDR_W-1:0] mem_addr_i,
  input logic                        busy_i,
  input logic                        evt_i
);

  int unsigned fail_cnt = 0;

  // A request waits for its grant with address and direction held
  req_held: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_i && !mem_gnt_i |=> mem_req_i && $stable(mem_addr_i) && $stable(mem_we_i))
    else begin
      fail_cnt++;
      $error("memory request dropped or changed before its grant");
    end

  evt_single: assert property (@(posedge clk_i) disable iff (reset_i)
    evt_i |=> !evt_i)
    else begin
      fail_cnt++;
      $error("end-of-job event longer than one cycle");
    end

  // busy ends on the same edge that raises the event
  busy_with_evt: assert property (@(posedge clk_i) disable iff (reset_i)
    $fell(busy_i) |-> evt_i)
    else begin
      fail_cnt++;
      $error("busy fell without an end-of-job event");
    end

endmodule

bind gemm_top gemm_properties i_props (
  .clk_i      ( clk_i      ),
  .reset_i    ( reset_i    ),
  .mem_req_i  ( mem_req_o  ),
  .mem_we_i   ( mem_we_o   ),
  .mem_gnt_i  ( mem_gnt_i  ),
  .mem_addr_i ( mem_addr_o ),
  .busy_i     ( busy_o     ),
  .evt_i      ( evt_o      )
);

/* dv/gemm_checker.sv */
// ##################
// Watches the GEMM ports and compares Z writes, busy, grants and STATUS reads
// Expected Z words and the Z base come from the testbench
// ##################
`timescale 1ns/1ps

module gemm_checker #(
  parameter int unsigned Width = gemm_pkg::ARRAY_WIDTH
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   periph_req_i,
  input  logic                                   periph_we_i,
  input  logic [7:0]                             periph_addr_i,
  input  logic                                   periph_gnt_i,
  input  logic [gemm_pkg::DATA_W-1:0]            periph_rdata_i,
  input  logic                                   mem_req_i,
  input  logic                                   mem_we_i,
  input  logic                                   mem_gnt_i,
  input  logic [gemm_pkg::ADDR_W-1:0]            mem_addr_i,
  input  logic [gemm_pkg::DATA_W-1:0]            mem_wdata_i,
  input  logic                                   busy_i,
  input  logic                                   evt_i,
  input  logic [gemm_pkg::ADDR_W-1:0]            z_base_i,
  input  logic [Width-1:0][gemm_pkg::DATA_W-1:0] exp_z_i,
  output int                                     mismatch_cnt_o,
  output int                                     other_cnt_o
);
  import gemm_pkg::*;

  logic exp_busy_q;
  int unsigned row_writes [Width];

  initial begin
    mismatch_cnt_o = 0;
    other_cnt_o    = 0;
  end

  always @(posedge clk_i) begin : compare
    logic busy_now;
    int unsigned row;
    // busy drops on the edge that raises the event
    busy_now = exp_busy_q && !evt_i;
    if (reset_i) begin
      exp_busy_q <= 1'b0;
      for (int r = 0; r < Width; r++) begin
        row_writes[r] = 0;
      end
    end else begin
      if (busy_i !== busy_now) begin
        mismatch_cnt_o++;
        $display("mismatch at %0t: busy_o is %b, expected %b", $time, busy_i, busy_now);
      end
      // The peripheral port is always ready
      if (periph_gnt_i !== periph_req_i) begin
        mismatch_cnt_o++;
        $display("mismatch at %0t: periph_gnt_o is %b, expected %b", $time, periph_gnt_i,
                 periph_req_i);
      end
      if (evt_i && !exp_busy_q) begin
        other_cnt_o++;
        $display("Error at %0t: end-of-job event without a running job", $time);
      end
      if (mem_req_i !== 1'b0 && !exp_busy_q) begin
        other_cnt_o++;
        $display("Error at %0t: memory request while no job runs", $time);
      end
      if (periph_req_i && !periph_we_i && periph_addr_i == REG_STATUS &&
          periph_rdata_i !== DATA_W'(busy_now)) begin
        mismatch_cnt_o++;
        $display("mismatch at %0t: STATUS read %h, expected %h", $time, periph_rdata_i,
                 DATA_W'(busy_now));
      end
      if (mem_req_i && mem_gnt_i && mem_we_i) begin
        row = ADDR_W'(mem_addr_i - z_base_i);
        if (row >= Width) begin
          mismatch_cnt_o++;
          $display("mismatch at %0t: write to %h outside the Z rows from %h", $time,
                   mem_addr_i, z_base_i);
        end else begin
          row_writes[row]++;
          if (mem_wdata_i !== exp_z_i[row]) begin
            mismatch_cnt_o++;
            $display("mismatch at %0t: Z row %0d is %h, expected %h", $time, row,
                     mem_wdata_i, exp_z_i[row]);
          end
        end
      end
      if (evt_i) begin
        for (int r = 0; r < Width; r++) begin
          if (row_writes[r] != 1) begin
            other_cnt_o++;
            $display("Error at %0t: Z row %0d written %0d times in the job", $time, r,
                     row_writes[r]);
          end
          row_writes[r] = 0;
        end
      end
      // A trigger counts only while idle
      if (evt_i) begin
        exp_busy_q <= 1'b0;
      end else if (periph_req_i && periph_we_i && periph_addr_i == REG_TRIGGER) begin
        exp_busy_q <= 1'b1;
      end
    end
  end

endmodule

/* dv/tb_gemm.sv */
// ##################
// Testbench top for gemm_top with a memory model and random grants
// Runs every case of dv/gemm_cases.txt and waits for each end-of-job event
// ##################
`timescale 1ns/1ps

module tb_gemm;
  import gemm_pkg::*;

  localparam int unsigned Width  = ARRAY_WIDTH;
  localparam int unsigned Height = ARRAY_HEIGHT;
  localparam int CASE_WORDS = 256;
  localparam logic [DATA_W-1:0] END_MARK = 32'hffff_ffff;
  localparam logic [ADDR_W-1:0] X_BASE = 16'h0010;
  localparam logic [ADDR_W-1:0] W_BASE = 16'h0030;
  localparam logic [ADDR_W-1:0] Y_BASE = 16'h0050;
  localparam logic [ADDR_W-1:0] Z_BASE = 16'h0080;

  logic clk_i = 1'b0;
  logic reset_i;
  logic periph_req_i, periph_we_i, periph_gnt_o;
  logic [7:0] periph_addr_i;
  logic [DATA_W-1:0] periph_wdata_i, periph_rdata_o;
  logic mem_req_o, mem_we_o, mem_gnt_i, mem_rvalid_i;
  logic [ADDR_W-1:0] mem_addr_o;
  logic [DATA_W-1:0] mem_wdata_o, mem_rdata_i;
  logic busy_o, evt_o;

  logic [DATA_W-1:0] cases_mem [CASE_WORDS];
  logic [DATA_W-1:0] mem [65536];
  logic [ADDR_W-1:0] z_base;
  logic [Width-1:0][DATA_W-1:0] exp_z;
  logic [31:0] rnd = 32'd6;
  int cycle_cnt = 0;
  int cycle_limit;
  int mismatch_cnt, other_cnt;

  gemm_top #(.Width(Width), .Height(Height)) uut (.*);

  gemm_checker #(.Width(Width)) i_checker (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .periph_req_i   ( periph_req_i   ),
    .periph_we_i    ( periph_we_i    ),
    .periph_addr_i  ( periph_addr_i  ),
    .periph_gnt_i   ( periph_gnt_o   ),
    .periph_rdata_i ( periph_rdata_o ),
    .mem_req_i      ( mem_req_o      ),
    .mem_we_i       ( mem_we_o       ),
    .mem_gnt_i      ( mem_gnt_i      ),
    .mem_addr_i     ( mem_addr_o     ),
    .mem_wdata_i    ( mem_wdata_o    ),
    .busy_i         ( busy_o         ),
    .evt_i          ( evt_o          ),
    .z_base_i       ( z_base         ),
    .exp_z_i        ( exp_z          ),
    .mismatch_cnt_o ( mismatch_cnt   ),
    .other_cnt_o    ( other_cnt      )
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Grants are random, read data comes back one cycle after the grant
  always @(posedge clk_i) begin : mem_model
    logic rd_hit;
    logic [ADDR_W-1:0] rd_addr;
    rd_hit  = !reset_i && mem_req_o && mem_gnt_i && !mem_we_o;
    rd_addr = mem_addr_o;
    if (!reset_i && mem_req_o && mem_gnt_i && mem_we_o) begin
      mem[mem_addr_o] = mem_wdata_o;
    end
    #2;
    mem_rvalid_i = rd_hit;
    mem_rdata_i  = rd_hit ? mem[rd_addr] : '0;
    rnd          = xorshift32(rnd);
    mem_gnt_i    = (rnd[1:0] != 2'b00);
  end

  task automatic report_counts;
    $display("Errors: %0d mismatch, %0d other, %0d assertion", mismatch_cnt, other_cnt,
             uut.i_props.fail_cnt);
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      report_counts();
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic periph_access(input logic we, input logic [7:0] addr,
                               input logic [DATA_W-1:0] data);
    @(posedge clk_i);
    #2;
    periph_req_i   = 1'b1;
    periph_we_i    = we;
    periph_addr_i  = addr;
    periph_wdata_i = data;
    @(posedge clk_i);
    #2;
    periph_req_i = 1'b0;
    periph_we_i  = 1'b0;
  endtask

  task automatic run_case(input int base, input int num);
    int k;
    int pos;
    k   = cases_mem[base];
    pos = base + 1;
    for (int i = 0; i < k; i++) begin
      mem[X_BASE + i] = cases_mem[pos + i];
      mem[W_BASE + i] = cases_mem[pos + k + i];
    end
    pos = pos + 2 * k;
    z_base = Z_BASE + ADDR_W'(8 * num);
    for (int r = 0; r < Width; r++) begin
      mem[Y_BASE + r] = cases_mem[pos + r];
      exp_z[r]        = cases_mem[pos + Width + r];
    end
    periph_access(1'b1, REG_X_ADDR, DATA_W'(X_BASE));
    periph_access(1'b1, REG_W_ADDR, DATA_W'(W_BASE));
    periph_access(1'b1, REG_Y_ADDR, DATA_W'(Y_BASE));
    periph_access(1'b1, REG_Z_ADDR, DATA_W'(z_base));
    periph_access(1'b1, REG_K, DATA_W'(k));
    periph_access(1'b1, REG_TRIGGER, 32'd1);
    periph_access(1'b0, REG_STATUS, '0);
    // Odd cases trigger again while the job runs
    if (num % 2 == 1) begin
      periph_access(1'b1, REG_TRIGGER, 32'd1);
    end
    @(posedge clk_i);
    while (!evt_o) begin
      @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
    periph_access(1'b0, REG_STATUS, '0);
  endtask

  initial begin
    int idx;
    int num;
    reset_i        = 1'b1;
    periph_req_i   = 1'b0;
    periph_we_i    = 1'b0;
    periph_addr_i  = '0;
    periph_wdata_i = '0;
    mem_gnt_i      = 1'b0;
    mem_rvalid_i   = 1'b0;
    mem_rdata_i    = '0;
    z_base         = '0;
    exp_z          = '0;
    $readmemh("dv/gemm_cases.txt", cases_mem);
    idx = 0;
    cycle_limit = 200;
    while (idx < CASE_WORDS && cases_mem[idx] !== END_MARK) begin
      cycle_limit += 50 * (2 * cases_mem[idx] + 2 * Width);
      idx += 1 + 2 * cases_mem[idx] + 2 * Width;
    end
    repeat (3) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    idx = 0;
    num = 0;
    while (idx < CASE_WORDS && cases_mem[idx] !== END_MARK) begin
      run_case(idx, num);
      idx += 1 + 2 * cases_mem[idx] + 2 * Width;
      num++;
    end
    repeat (4) @(posedge clk_i);
    report_counts();
    if (mismatch_cnt + other_cnt + uut.i_props.fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* project.f */
hw/gemm_pkg.sv
hw/gemm_regfile.sv
hw/gemm_scheduler.sv
hw/gemm_mem_arbiter.sv
hw/gemm_load_unit.sv
hw/gemm_engine.sv
hw/gemm_store_unit.sv
hw/gemm_top.sv
dv/gemm_properties.sv
dv/gemm_checker.sv
dv/tb_gemm.sv

/* dv/gemm_cases.txt */
// Per case: K, then K X words, K W words, 4 Y words and 4 expected Z words
// Byte i of a word is element i; X holds one element per row, W one per column
1 04030201 08070605 00000000 00000000 00000000 00000000 08070605 100e0c0a 1815120f 201c1814
2 01010101 03020100 04030201 0a0a0a0a 00000000 01010101 02020202 03030303 04030201 0f0e0d0c 1a191817 25242322
3 10101010 04030201 02020202 10101010 64646464 04030201 05050505 05050505 05050505 05050505 716f6d6b d5d3d1cf 39373533 9d9b9997
4 ffffffff ff01ff01 00000000 fefefefe 04030201 fdfdfdfd 07070707 01010101 00000000 00000000 00000000 00000000 f7f8f9fa fdfeff00 f7f8f9fa fdfeff00
5 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 7f7f7f7f 1080ff00 1080ff01 1080ff02 1080ff03 15850405 15850406 15850407 15850408
6 02010201 02010201 02010201 02010201 02010201 02010201 80000201 80000202 80000203 80000204 80000205 80000206 00000000 01010101 02020202 03030303 00000c15 0101192b 02020e17 03031b2d
// End marker
ffffffff
